// ==== project.f ====
mac_pkg.sv
mac_req_if.sv
mac_add.sv
mac_addr_queue.sv
mac_bus_issue.sv
cga_mac.sv
tb_cga_mac.sv

// ==== Makefile ====
# Verilator build and run for the CGA memory address path

VERILATOR ?= verilator
SIM_TOP   ?= tb_cga_mac
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit status of the pipe
run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_cga_mac.sv ====
// Testbench for the CGA memory address path driving LFSR stimulus and checking by assertions
`timescale 1ns/1ps

module tb_cga_mac
  import mac_pkg::*;
();

  localparam int QUEUE_DEPTH    = QUEUE_DEPTH_DEF;
  localparam int OPS_PER_PHASE  = 150;
  localparam int CYCLES_PER_OP  = 12;   // Generous bound for phase 4 with memory mostly busy
  localparam int TIMEOUT_CYCLES = 4 * OPS_PER_PHASE * CYCLES_PER_OP + 800;  // 8000
  localparam int DRIVE_DELAY    = 2;
  localparam int DRAIN_LIMIT    = QUEUE_DEPTH + 8;  // Full path empties well within this
  localparam logic [15:0] LFSR_SEED = 16'd63750;

  logic  clk;
  logic  reset;
  addr_t br;
  addr_t rb;
  addr_t xr;
  addr_t lca;
  logic  pb;
  logic  prb;
  logic  px;
  logic  plca;
  addr_t cd;
  logic  cds;
  logic  wr;
  logic  go;
  logic  ready;
  logic  mem_busy;
  logic  mem_req;
  addr_t mem_addr;
  logic  mem_wr;

  logic [15:0] lfsr_state;

  // Expected requests with wr in bit 16 above the address
  logic [16:0] exp_q [$];
  int          exp_count;
  addr_t       exp_front_addr;
  logic        exp_front_wr;
  int          accepted;
  int          ready_low_seen;
  int          cycle_count;

  logic        accept_mid;     // Captured mid cycle for the coming edge
  logic        req_mid;
  logic [16:0] entry_mid;
  logic        idle_accept;

  cga_mac #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) dut (
    .clk      (clk),
    .reset    (reset),
    .br       (br),
    .rb       (rb),
    .xr       (xr),
    .lca      (lca),
    .pb       (pb),
    .prb      (prb),
    .px       (px),
    .plca     (plca),
    .cd       (cd),
    .cds      (cds),
    .wr       (wr),
    .go       (go),
    .ready    (ready),
    .mem_busy (mem_busy),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_wr   (mem_wr)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // 16-bit maximal length taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    int i;
    v = 16'h0000;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
  endtask

  // Effective address as the CPU defines it
  function automatic logic [15:0] model_addr(
    input logic [15:0] b,
    input logic [15:0] r,
    input logic [15:0] x,
    input logic [15:0] l,
    input logic [3:0]  sel,
    input logic [15:0] d,
    input logic        byte_mode
  );
    logic [15:0] base;
    logic [15:0] ext;
    base = 16'h0000;
    if (sel[3]) base = base | b;
    if (sel[2]) base = base | r;
    if (sel[1]) base = base | x;
    if (sel[0]) base = base | l;
    if (!byte_mode)
      ext = d;
    else if (d[7])
      ext = 16'hFF00 | {8'h00, d[7:0]};   // Negative byte
    else
      ext = {8'h00, d[7:0]};
    return base + ext;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    fail_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, want));
  endtask

  task automatic drive_idle();
    br       = '0;
    rb       = '0;
    xr       = '0;
    lca      = '0;
    {pb, prb, px, plca} = 4'b0000;
    cd       = '0;
    cds      = 1'b0;
    wr       = 1'b0;
    go       = 1'b0;
    mem_busy = 1'b0;
  endtask

  task automatic drive_random(input int phase);
    logic [15:0] v;
    logic [3:0]  sel;
    take_bits(16, v);
    br = v;
    take_bits(16, v);
    rb = v;
    take_bits(16, v);
    xr = v;
    take_bits(16, v);
    lca = v;
    take_bits(16, v);
    cd = v;
    if (phase == 1) begin
      take_bits(3, v);
      sel = (v[2:0] == 3'd0) ? 4'b0000 : (4'b0001 << v[1:0]);  // One or none
    end else if (phase == 2) begin
      do begin
        take_bits(4, v);
        sel = v[3:0];
      end while ($countones(sel) < 2);
    end else begin
      take_bits(4, v);
      sel = v[3:0];
    end
    {pb, prb, px, plca} = sel;
    take_bits(1, v);
    cds = v[0];
    take_bits(1, v);
    wr = v[0];
    take_bits(2, v);
    go = (v[1:0] != 2'b00);
    if (phase == 4) begin
      take_bits(2, v);
      mem_busy = (v[1:0] != 2'b00);     // Busy three cycles in four
    end else begin
      mem_busy = 1'b0;
    end
  endtask

  // Inputs and outputs are all settled mid cycle
  always @(negedge clk) begin
    accept_mid = !reset && go && ready;
    req_mid    = !reset && mem_req;
    entry_mid  = {wr, model_addr(br, rb, xr, lca, {pb, prb, px, plca}, cd, cds)};
    if (!reset && !ready)
      ready_low_seen++;
  end

  always @(posedge clk) begin
    if (req_mid && exp_q.size() != 0)
      void'(exp_q.pop_front());
    if (accept_mid) begin
      exp_q.push_back(entry_mid);
      accepted++;
    end
    exp_count <= exp_q.size();
    if (exp_q.size() != 0)
      {exp_front_wr, exp_front_addr} <= exp_q[0];
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      fail_run($sformatf("Timeout, run went past %0d cycles", TIMEOUT_CYCLES));
  end

  assign idle_accept = go && ready && (exp_count == 0);

  a_reset_req: assert property (@(posedge clk) $fell(reset) |-> !mem_req)
    else value_mismatch("mem_req", 32'($sampled(mem_req)), 32'd0);

  a_reset_ready: assert property (@(posedge clk) $fell(reset) |-> ready)
    else value_mismatch("ready", 32'($sampled(ready)), 32'd1);

  a_req_expected: assert property (
    @(posedge clk) disable iff (reset) mem_req |-> exp_count != 0
  ) else fail_run("Memory request issued with no address outstanding");

  a_addr_order: assert property (
    @(posedge clk) disable iff (reset)
    mem_req && exp_count != 0 |-> mem_addr == exp_front_addr
  ) else value_mismatch("mem_addr", 32'($sampled(mem_addr)), 32'($sampled(exp_front_addr)));

  a_wr_order: assert property (
    @(posedge clk) disable iff (reset)
    mem_req && exp_count != 0 |-> mem_wr == exp_front_wr
  ) else value_mismatch("mem_wr", 32'($sampled(mem_wr)), 32'($sampled(exp_front_wr)));

  // Empty path and idle memory give the two edge latency
  a_idle_latency: assert property (
    @(posedge clk) disable iff (reset)
    $past(idle_accept, 3) && !$past(mem_busy) |-> mem_req
  ) else value_mismatch("mem_req", 32'($sampled(mem_req)), 32'd1);

  a_busy_blocks: assert property (
    @(posedge clk) disable iff (reset) mem_req |-> !$past(mem_busy)
  ) else fail_run("Memory request issued right after memory reported busy");

  // Ready drops only with the queue full and the adder holding one more
  a_ready_full: assert property (
    @(posedge clk) disable iff (reset)
    ready == ((exp_count - int'(mem_req)) <= QUEUE_DEPTH)
  ) else value_mismatch("ready", 32'($sampled(ready)),
                        32'(($sampled(exp_count) - int'($sampled(mem_req))) <= QUEUE_DEPTH));

  a_capacity: assert property (
    @(posedge clk) disable iff (reset) exp_count <= QUEUE_DEPTH + 2
  ) else fail_run("More addresses outstanding than the path can hold");

  initial begin
    int phase;
    int target;
    int drain;
    lfsr_state     = LFSR_SEED;
    accepted       = 0;
    ready_low_seen = 0;
    cycle_count    = 0;
    exp_count      = 0;
    exp_front_addr = '0;
    exp_front_wr   = 1'b0;
    reset          = 1'b1;
    drive_idle();
    repeat (10) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    for (phase = 1; phase <= 4; phase++) begin
      target = accepted + OPS_PER_PHASE;
      while (accepted < target) begin
        @(posedge clk);
        #DRIVE_DELAY;
        drive_random(phase);
      end
    end

    // Drain with memory idle
    @(posedge clk);
    #DRIVE_DELAY;
    drive_idle();
    drain = 0;
    while (exp_q.size() != 0 && drain < DRAIN_LIMIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      drain++;
    end
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;

    if (exp_q.size() != 0) begin
      fail_run("Expected addresses left over at end of run");
    end else if (ready_low_seen == 0) begin
      fail_run("Back-pressure never pulled ready low");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== cga_mac.sv ====
// CGA memory address path top level joining address adder, address queue and bus issuer
`timescale 1ns/1ps

module cga_mac
  import mac_pkg::*;
#(
  parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEF
) (
  input  logic  clk,
  input  logic  reset,

  // Base registers and their selects
  input  addr_t br,
  input  addr_t rb,
  input  addr_t xr,
  input  addr_t lca,
  input  logic  pb,
  input  logic  prb,
  input  logic  px,
  input  logic  plca,

  input  addr_t cd,        // CPU data displacement
  input  logic  cds,       // Low byte only, sign extended
  input  logic  wr,

  input  logic  go,
  output logic  ready,     // go ignored while low

  // Memory side
  input  logic  mem_busy,
  output logic  mem_req,
  output addr_t mem_addr,
  output logic  mem_wr
);

  mac_req_if add_q ();     // Adder to queue
  mac_req_if q_iss ();     // Queue to issuer

  mac_add u_add (
    .clk   (clk),
    .reset (reset),
    .go    (go),
    .br    (br),
    .rb    (rb),
    .xr    (xr),
    .lca   (lca),
    .pb    (pb),
    .prb   (prb),
    .px    (px),
    .plca  (plca),
    .cd    (disp_u'(cd)),
    .cds   (cds),
    .wr    (wr),
    .ready (ready),
    .out   (add_q.source)
  );

  mac_addr_queue #(
    .DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk   (clk),
    .reset (reset),
    .in    (add_q.sink),
    .out   (q_iss.source)
  );

  mac_bus_issue u_issue (
    .clk      (clk),
    .reset    (reset),
    .mem_busy (mem_busy),
    .in       (q_iss.sink),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_wr   (mem_wr)
  );

endmodule

// ==== mac_bus_issue.sv ====
// MAC bus issuer that takes the queue head and presents it to memory as a one-cycle request
`timescale 1ns/1ps

module mac_bus_issue
  import mac_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  mem_busy,   // Memory cannot accept a request
  mac_req_if.sink in,
  output logic  mem_req,    // One-cycle request strobe
  output addr_t mem_addr,
  output logic  mem_wr
);

  logic take;

  // Memory busy is the only thing that holds the head back
  assign in.stall = mem_busy;
  assign take     = in.put & ~mem_busy;

  always_ff @(posedge clk) begin
    if (reset)
      mem_req <= 1'b0;
    else
      mem_req <= take;      // Back to back when items keep coming
  end

  // Address and direction valid alongside mem_req
  always_ff @(posedge clk) begin
    if (take) begin
      mem_addr <= in.addr;
      mem_wr   <= in.wr;
    end
  end

  // A request is never stretched unless a new item was taken
  a_req_pulse: assert property (
    @(posedge clk) disable iff (reset)
    mem_req && !take |=> !mem_req
  ) else $error("mac_bus_issue mem_req held without a new item");

endmodule

// ==== mac_addr_queue.sv ====
// MAC address queue buffering pending address and write flag pairs between adder and issuer
`timescale 1ns/1ps

module mac_addr_queue
  import mac_pkg::*;
#(
  parameter int DEPTH = QUEUE_DEPTH_DEF
) (
  input  logic clk,
  input  logic reset,
  mac_req_if.sink   in,
  mac_req_if.source out
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  addr_t            addr_mem [DEPTH];
  logic             wr_mem   [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Full queue holds off the adder
  assign in.stall = (count == CNT_W'(DEPTH));
  assign push     = in.put & ~in.stall;

  // Head is offered whenever anything is stored
  assign out.put  = (count != '0);
  assign out.addr = addr_mem[rd_ptr];
  assign out.wr   = wr_mem[rd_ptr];
  assign pop      = out.put & ~out.stall;

  // Storage, no reset needed on payload
  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr] <= in.addr;
      wr_mem[wr_ptr]   <= in.wr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == PTR_W'(DEPTH - 1))
          wr_ptr <= '0;
        else
          wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        if (rd_ptr == PTR_W'(DEPTH - 1))
          rd_ptr <= '0;
        else
          rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset)
    count <= CNT_W'(DEPTH)
  ) else $error("mac_addr_queue count above DEPTH");

  // An empty queue stays empty unless the adder delivers
  a_no_underflow: assert property (
    @(posedge clk) disable iff (reset)
    (count == '0) && !push |=> (count == '0)
  ) else $error("mac_addr_queue count wrapped below zero");

endmodule

// ==== mac_add.sv ====
// MAC address adder that ORs the selected base registers, adds the CD displacement and holds the result
`timescale 1ns/1ps

module mac_add
  import mac_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  go,     // Request one address
  input  addr_t br,     // B register
  input  addr_t rb,     // Microcode register B
  input  addr_t xr,     // X register
  input  addr_t lca,    // Load control address
  input  logic  pb,
  input  logic  prb,
  input  logic  px,
  input  logic  plca,
  input  disp_u cd,     // CPU data displacement
  input  logic  cds,    // Byte displacement mode
  input  logic  wr,
  output logic  ready,
  mac_req_if.source out
);

  addr_t base;
  addr_t disp;
  addr_t sum;
  logic  take;

  // Wired-OR of whichever base registers are selected, zero when none
  always_comb begin
    base = '0;
    if (pb)
      base = base | br;
    if (prb)
      base = base | rb;
    if (px)
      base = base | xr;
    if (plca)
      base = base | lca;
  end

  // Byte mode drops the high byte and extends bit 7 upward
  always_comb begin
    if (cds)
      disp = {{(ADDR_W-8){cd.bytes.lo[7]}}, cd.bytes.lo};
    else
      disp = cd.word;
  end

  assign sum = base + disp;  // Wraps modulo 2^16

  // Busy only while an item sits here that the queue has not taken
  assign ready = ~(out.put & out.stall);
  assign take  = go & ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out.put <= 1'b0;
    end else if (take) begin
      out.put <= 1'b1;
    end else if (!out.stall) begin
      out.put <= 1'b0;        // Item moved, nothing new
    end
  end

  // Result register toward the queue
  always_ff @(posedge clk) begin
    if (take) begin
      out.addr <= sum;
      out.wr   <= wr;
    end
  end

  // A held item stays offered and unchanged until the queue has room
  a_hold_item: assert property (
    @(posedge clk) disable iff (reset)
    out.put && out.stall |=> out.put && $stable(out.addr) && $stable(out.wr)
  ) else $error("mac_add dropped or changed an item under stall");

endmodule

// ==== mac_req_if.sv ====
// Address request link carrying one memory address and its write flag between MAC blocks
`timescale 1ns/1ps

interface mac_req_if
  import mac_pkg::*;
();

  logic  put;    // Item offered this cycle
  addr_t addr;   // Memory address
  logic  wr;     // High for a write cycle
  logic  stall;  // Sink cannot take the item

  // An item moves on an edge with put high and stall low.
  // The source holds put, addr and wr steady while stall is high.
  modport source (
    output put,
    output addr,
    output wr,
    input  stall
  );

  modport sink (
    input  put,
    input  addr,
    input  wr,
    output stall
  );

endinterface

// ==== mac_pkg.sv ====
// CGA MAC shared package holding the address word type and the CD displacement decode

package mac_pkg;

  // Memory address width of the minicomputer bus
  localparam int ADDR_W = 16;

  // Address queue entries between adder and bus issuer
  localparam int QUEUE_DEPTH_DEF = 4;

  // One memory address word; also the shape of BR, RB, XR and LCA
  typedef logic [ADDR_W-1:0] addr_t;

  // CPU data word as seen by the address adder.
  // With CDS low the whole word is the displacement. With CDS high only the
  // low byte counts, as a signed value, and the high byte is don't care.
  typedef union packed {
    addr_t word;              // Full 16-bit displacement
    struct packed {
      logic [7:0] hi;         // Ignored in byte mode
      logic [7:0] lo;         // Signed byte, bit 7 is sign
    } bytes;
  } disp_u;

endpackage
